// ==== project.f ====
+incdir+source
source/rv_pkg.sv
source/fetch_stage.sv
source/instr_decoder.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_stage.sv
source/rv_core.sv
verification/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the rv_core testbench with Verilator, from the project root
set -e

verilator --binary --timing -j 0 --top-module rv_core_tb -f project.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim) || true
echo "$out"

echo "$out" | grep -q "Test passed"

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module execute_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  rv_pkg::decoded_t decoded,
  input  logic [`XLEN-1:0] id_pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  rv_pkg::wb_t      wb,
  output rv_pkg::ex_mem_t  ex_mem
);

  import rv_pkg::*;

  decoded_t         id_ex;
  logic [`XLEN-1:0] id_ex_pc;
  logic [`XLEN-1:0] id_ex_rs1_data;
  logic [`XLEN-1:0] id_ex_rs2_data;
  logic [`XLEN-1:0] fwd_rs1;
  logic [`XLEN-1:0] fwd_rs2;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;

  // youngest producer wins, x0 never forwards
  function automatic logic [`XLEN-1:0] fwd_sel(
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`XLEN-1:0]       rf_val,
    input ex_mem_t                em,
    input wb_t                    mw
  );
    if (rs != '0 && em.reg_write && em.rd == rs) begin
      return em.result;
    end
    if (rs != '0 && mw.reg_write && mw.rd == rs) begin
      return mw.data;
    end
    return rf_val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.ctrl <= '0;
    end else if (!stall) begin
      id_ex          <= decoded;
      id_ex_pc       <= id_pc;
      id_ex_rs1_data <= rs1_data;
      id_ex_rs2_data <= rs2_data;
    end
  end

  assign fwd_rs1 = fwd_sel(id_ex.rs1, id_ex_rs1_data, ex_mem, wb);
  assign fwd_rs2 = fwd_sel(id_ex.rs2, id_ex_rs2_data, ex_mem, wb);

  assign op_a = id_ex.ctrl.src_a_pc  ? id_ex_pc  : fwd_rs1;  // auipc
  assign op_b = id_ex.ctrl.src_b_imm ? id_ex.imm : fwd_rs2;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      default:    alu_out = op_b;  // pass b
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_write <= 1'b0;
    end else if (!stall) begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.result     <= alu_out;
      ex_mem.store_data <= fwd_rs2;  // sw data, already forwarded
    end
  end

  // a store never writes back
  store_no_wb_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(ex_mem.reg_write && ex_mem.mem_write));

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module fetch_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  output logic [`XLEN-1:0] imem_addr,
  output logic             imem_valid,
  input  logic             imem_good,
  input  logic [`XLEN-1:0] imem_instr,
  output logic [`XLEN-1:0] if_instr,
  output logic [`XLEN-1:0] if_pc
);

  logic [`XLEN-1:0] pc;
  logic             fetch_en;  // low only in the cycle reset is released
  logic             take;

  assign imem_addr  = pc;
  assign imem_valid = fetch_en && !stall;
  assign take       = imem_valid && imem_good;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en <= 1'b0;
      pc       <= `PC_RESET;
      if_instr <= `NOP_INSTR;
      if_pc    <= `PC_RESET;
    end else begin
      fetch_en <= 1'b1;
      if (!stall) begin
        if (take) begin
          pc <= pc + `XLEN'd4;
        end
        // no instruction this cycle, so pass a bubble down
        if_instr <= take ? imem_instr : `NOP_INSTR;
        if_pc    <= pc;
      end
    end
  end

  // no branches, so the pc only ever steps by a word
  pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00);

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module instr_decoder (
  input  logic [`XLEN-1:0] instr,
  output rv_pkg::decoded_t decoded
);

  import rv_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm;
  alu_op_e          alu_op;
  ex_ctrl_t         ctrl;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // alu control, same table for register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == OP && funct7[5]) ? ALU_SUB : ALU_ADD;  // no subi
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // srai also has bit 30 set
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      OP: begin
        ctrl.alu_op    = alu_op;
        ctrl.reg_write = 1'b1;
      end
      OP_IMM: begin
        ctrl.alu_op    = alu_op;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_i;
      end
      LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      AUIPC: begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      STORE: begin
        ctrl.alu_op    = ALU_ADD;  // base + offset
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        imm            = imm_s;
      end
      default: ;  // anything else is a bubble
    endcase
  end

  assign decoded = '{
    ctrl: ctrl,
    imm:  imm,
    rs1:  instr[19:15],
    rs2:  instr[24:20],
    rd:   instr[11:7]
  };

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module mem_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  rv_pkg::ex_mem_t  ex_mem,
  output logic             dmem_valid,
  input  logic             dmem_good,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_write_data,
  output rv_pkg::wb_t      wb
);

  // word store straight from EX/MEM, held there by stall
  assign dmem_valid      = ex_mem.mem_write;
  assign dmem_addr       = ex_mem.result;
  assign dmem_write_data = ex_mem.store_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.reg_write <= 1'b0;
    end else if (!stall) begin
      wb.reg_write <= ex_mem.reg_write;  // low for stores and bubbles
      wb.rd        <= ex_mem.rd;
      wb.data      <= ex_mem.result;
    end
  end

  // request held until dmem takes it
  dmem_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_valid && !dmem_good) |=>
      (dmem_valid && $stable(dmem_addr) && $stable(dmem_write_data)));

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  rv_pkg::wb_t            wb,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             wr_en;

  assign wr_en = wb.reg_write && (wb.rd != '0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write-first, covers a producer three instructions back
  assign rs1_data = (wr_en && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2_data = (wr_en && wb.rd == rs2) ? wb.data : regs[rs2];

  x0_reads_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
    ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)));

endmodule

// ==== source/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and address width
`define XLEN 32

// register index width and count
`define REG_ADDR_W 5
`define NUM_REGS 32

// first fetch address out of reset
`define PC_RESET 32'h0000_0000

// addi x0, x0, 0
// fetch loads this into IF/ID as a bubble
`define NOP_INSTR 32'h0000_0013

`endif

// ==== source/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst_n,
  output logic [`XLEN-1:0] imem_addr,
  output logic             imem_valid,
  input  logic             imem_good,
  input  logic [`XLEN-1:0] imem_instr,
  output logic             dmem_valid,
  input  logic             dmem_good,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_write_data
);

  import rv_pkg::*;

  logic             stall;
  logic [`XLEN-1:0] if_instr;
  logic [`XLEN-1:0] if_pc;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  decoded_t         decoded;
  ex_mem_t          ex_mem;
  wb_t              wb;

  // only a pending store holds the pipe
  assign stall = dmem_valid && !dmem_good;

  fetch_stage u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .imem_addr  (imem_addr),
    .imem_valid (imem_valid),
    .imem_good  (imem_good),
    .imem_instr (imem_instr),
    .if_instr   (if_instr),
    .if_pc      (if_pc)
  );

  instr_decoder u_decoder (
    .instr   (if_instr),
    .decoded (decoded)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (decoded.rs1),
    .rs2      (decoded.rs2),
    .wb       (wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .decoded  (decoded),
    .id_pc    (if_pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .ex_mem   (ex_mem)
  );

  mem_stage u_mem (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .ex_mem          (ex_mem),
    .dmem_valid      (dmem_valid),
    .dmem_good       (dmem_good),
    .dmem_addr       (dmem_addr),
    .dmem_write_data (dmem_write_data),
    .wb              (wb)
  );

endmodule

// ==== source/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  // major opcodes this core executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    src_a_pc;   // operand a is the pc
    logic    src_b_imm;  // operand b is the immediate
    logic    reg_write;
    logic    mem_write;
  } ex_ctrl_t;

  typedef struct packed {
    ex_ctrl_t                ctrl;
    logic [`XLEN-1:0]        imm;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`REG_ADDR_W-1:0]  rd;
  } decoded_t;

  typedef struct packed {
    logic                    reg_write;
    logic                    mem_write;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`XLEN-1:0]        result;      // alu result, store address for sw
    logic [`XLEN-1:0]        store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                    reg_write;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`XLEN-1:0]        data;
  } wb_t;

endpackage

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_tb;

  localparam int CLK_HALF    = 10;
  localparam int DRIVE_DELAY = 2;
  localparam int WAIT_LIMIT  = 200;  // cycles allowed for any single event
  localparam int END_WINDOW  = 50;

  logic             clk;
  logic             rst_n;
  logic [`XLEN-1:0] imem_addr;
  logic             imem_valid;
  logic             imem_good;
  logic [`XLEN-1:0] imem_instr;
  logic             dmem_valid;
  logic             dmem_good;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_write_data;

  logic [31:0]      program_mem [$];
  logic [31:0]      exp_addr [$];
  logic [31:0]      exp_data [$];
  logic [31:0]      lfsr;
  logic             held;
  logic [31:0]      held_addr;
  logic [31:0]      held_data;

  rv_core rv_core_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .imem_addr       (imem_addr),
    .imem_valid      (imem_valid),
    .imem_good       (imem_good),
    .imem_instr      (imem_instr),
    .dmem_valid      (dmem_valid),
    .dmem_good       (dmem_good),
    .dmem_addr       (dmem_addr),
    .dmem_write_data (dmem_write_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns %s: got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%0d ns %s", $time, reason);
    $display("Test failed");
    $fatal(1);
  endtask

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < program_mem.size()) begin
      return program_mem[idx];
    end
    return `NOP_INSTR;  // past the end of the program
  endfunction

  task automatic load_vectors();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("verification/rv_core_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "I %h", a) == 1) begin
        program_mem.push_back(a);
      end else if ($sscanf(line, "S %h %h", a, d) == 2) begin
        exp_addr.push_back(a);
        exp_data.push_back(d);
      end
    end
    $fclose(fd);
  endtask

  // memory models answer a short delay after each rising edge
  initial begin
    imem_good  = 1'b0;
    dmem_good  = 1'b0;
    imem_instr = `NOP_INSTR;
    lfsr       = 32'h6929;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      imem_good  = next_rand_bit();
      dmem_good  = next_rand_bit();
      imem_instr = fetch_word(imem_addr);
    end
  end

  // a refused store must keep its address and data
  always @(negedge clk) begin
    if (rst_n) begin
      if (held) begin
        check_value({31'b0, dmem_valid}, 32'd1, "dmem_valid dropped while not accepted");
        check_value(dmem_addr, held_addr, "dmem_addr changed under back-pressure");
        check_value(dmem_write_data, held_data, "dmem_write_data changed under back-pressure");
      end
      if (dmem_valid && !dmem_good) begin
        check_value({31'b0, imem_valid}, 32'd0, "imem_valid during a stall");
      end
      held      = dmem_valid && !dmem_good;
      held_addr = dmem_addr;
      held_data = dmem_write_data;
    end else begin
      held = 1'b0;
    end
  end

  task automatic wait_store(input int n);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(dmem_valid && dmem_good)) begin
      if (cycles == WAIT_LIMIT) begin
        $display("store %0d never completed", n);
        abort_run("timeout waiting for a store");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  initial begin
    int cycles;
    rst_n = 1'b0;
    load_vectors();

    repeat (5) begin
      @(negedge clk);
      check_value({31'b0, dmem_valid}, 32'd0, "dmem_valid in reset");
      check_value({31'b0, imem_valid}, 32'd0, "imem_valid in reset");
    end
    @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;

    cycles = 0;
    @(negedge clk);
    while (!imem_valid) begin
      if (cycles == WAIT_LIMIT) begin
        abort_run("timeout waiting for the first instruction fetch");
      end
      @(negedge clk);
      cycles++;
    end
    check_value({31'b0, dmem_valid}, 32'd0, "dmem_valid right after reset");
    check_value(imem_addr, `PC_RESET, "first imem_addr");

    for (int n = 0; n < exp_addr.size(); n++) begin
      wait_store(n);
      check_value(dmem_addr, exp_addr[n], $sformatf("store %0d address", n));
      check_value(dmem_write_data, exp_data[n], $sformatf("store %0d data", n));
      @(posedge clk);
    end

    repeat (END_WINDOW) begin
      @(negedge clk);
      check_value({31'b0, dmem_valid}, 32'd0, "dmem_valid after the last store");
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== verification/rv_core_vectors.txt ====
# I <instruction hex>            program words from address 0
# S <address hex> <data hex>     expected stores in program order
I 06400093
I FF900113
I 002081B3
I 00302023
I 40208233
I 00402223
I 002092B3
I 00112333
I 001133B3
I 00502423
I 00602623
I 00702823
I 0020C433
I 001154B3
I 40115533
I 0020E5B3
I 0020F633
I 00802A23
I 00902C23
I 00A02E23
I 02B02023
I 02C02223
I FFA12693
I FFF0B713
I 00F0C793
I 0F017813
I 7000E893
I 00409913
I 01C15993
I 40115A13
I 02D02423
I 02E02623
I 02F02823
I 03002A23
I 03102C23
I 03202E23
I 05302023
I 05402223
I 12345AB7
I 00001B17
I 00508013
I 05502423
I 05602623
I 04002823
I 20000B93
I 001B8C13
I 001C0C93
I 019BA023
S 00000000 0000005D
S 00000004 0000006B
S 00000008 C8000000
S 0000000C 00000001
S 00000010 00000000
S 00000014 FFFFFF9D
S 00000018 0FFFFFFF
S 0000001C FFFFFFFF
S 00000020 FFFFFFFD
S 00000024 00000060
S 00000028 00000001
S 0000002C 00000001
S 00000030 0000006B
S 00000034 000000F0
S 00000038 00000764
S 0000003C 00000640
S 00000040 0000000F
S 00000044 FFFFFFFC
S 00000048 12345000
S 0000004C 0000109C
S 00000050 00000000
S 00000200 00000202
